// File: tb.f
hw/ascon_pkg.sv
hw/ascon_round.sv
hw/ascon_absorb.sv
hw/ascon_sequencer.sv
hw/ascon_state.sv
hw/ascon_core.sv
sim/tb_clock.sv
sim/ascon_properties.sv
sim/tb_ascon.sv

// File: run.sh
#!/usr/bin/env bash
# Build the Ascon testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir

verilator --binary --timing --assert --top-module tb_ascon \
    -f tb.f -o sim_ascon > build.log 2>&1 \
    || { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/sim_ascon > sim.log 2>&1
cat sim.log

grep -qx "NO ERRORS" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// File: sim/tb_ascon.sv
// Ascon core testbench: LFSR stimulus, reference model, result comparison,
// timeout and summary
`timescale 1ns/1ps
`default_nettype none

module tb_ascon;

    localparam int CMD_COUNT   = 26;
    localparam int CYCLE_LIMIT = CMD_COUNT * 14 + 300;
    localparam int EXP_NONE    = 0;
    localparam int EXP_CT      = 1;
    localparam int EXP_TAG     = 2;

    // 5-bit S-box, x0 is the MSB of a column
    localparam logic [4:0] SBOX [32] = '{
        5'h04, 5'h0b, 5'h1f, 5'h14, 5'h1a, 5'h15, 5'h09, 5'h02,
        5'h1b, 5'h05, 5'h08, 5'h12, 5'h1d, 5'h03, 5'h06, 5'h1c,
        5'h1e, 5'h13, 5'h07, 5'h0e, 5'h00, 5'h0d, 5'h11, 5'h18,
        5'h10, 5'h0c, 5'h01, 5'h19, 5'h16, 5'h0a, 5'h0f, 5'h17
    };

    logic         clk;
    logic         reset_n_lfsr;
    logic [63:0]  i_key1;
    logic [63:0]  i_key2;
    logic [63:0]  i_nonce1;
    logic [63:0]  i_nonce2;
    logic [63:0]  i_iv;
    logic [127:0] i_data;
    logic [3:0]   i_valid_bytes;
    logic         i_last;
    logic         i_init;
    logic         i_absorb;
    logic         i_final;
    logic [127:0] o_ciphertext;
    logic [127:0] o_tag;
    logic         o_busy;
    logic         o_done;

    logic [31:0]  lfsr_state;
    logic [319:0] ref_state;
    logic [63:0]  ref_key1;
    logic [63:0]  ref_key2;
    int           exp_kind_q [$];
    logic [127:0] exp_value_q [$];
    int           result_idx    = 0;
    int           result_checks = 0;
    int           result_errors = 0;
    int           stim_errors   = 0;
    int           cycle_count   = 0;
    logic         done_seen     = 1'b0;

    tb_clock u_clock (
        .clk          (clk),
        .reset_n_lfsr (reset_n_lfsr)
    );

    ascon_core i_dut (
        .clk           (clk),
        .reset_n_lfsr  (reset_n_lfsr),
        .i_key1        (i_key1),
        .i_key2        (i_key2),
        .i_nonce1      (i_nonce1),
        .i_nonce2      (i_nonce2),
        .i_iv          (i_iv),
        .i_data        (i_data),
        .i_valid_bytes (i_valid_bytes),
        .i_last        (i_last),
        .i_init        (i_init),
        .i_absorb      (i_absorb),
        .i_final       (i_final),
        .o_ciphertext  (o_ciphertext),
        .o_tag         (o_tag),
        .o_busy        (o_busy),
        .o_done        (o_done)
    );

    // ------------------------------
    // Random source
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    task automatic draw_bits(input int n, output logic [127:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[126:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // ------------------------------
    // Reference model
    function automatic logic [63:0] rot_right(input logic [63:0] w, input int n);
        return (w >> n) | (w << (64 - n));
    endfunction

    function automatic logic [319:0] ref_round(input logic [319:0] s, input int r);
        logic [63:0] x [5];
        logic [63:0] y [5];
        logic [4:0]  sub;
        for (int i = 0; i < 5; i++) begin
            x[i] = s[64*i +: 64];
        end
        // Constant byte is (15 - r) in the high nibble and r in the low one
        x[2][7:0] = x[2][7:0] ^ {4'(15 - r), 4'(r)};
        for (int b = 0; b < 64; b++) begin
            sub = SBOX[{x[0][b], x[1][b], x[2][b], x[3][b], x[4][b]}];
            y[0][b] = sub[4];
            y[1][b] = sub[3];
            y[2][b] = sub[2];
            y[3][b] = sub[1];
            y[4][b] = sub[0];
        end
        return {y[4] ^ rot_right(y[4], 7)  ^ rot_right(y[4], 41),
                y[3] ^ rot_right(y[3], 10) ^ rot_right(y[3], 17),
                y[2] ^ rot_right(y[2], 1)  ^ rot_right(y[2], 6),
                y[1] ^ rot_right(y[1], 61) ^ rot_right(y[1], 39),
                y[0] ^ rot_right(y[0], 19) ^ rot_right(y[0], 28)};
    endfunction

    function automatic logic [319:0] ref_permute(input logic [319:0] s, input int first);
        logic [319:0] t;
        t = s;
        for (int r = first; r < 12; r++) begin
            t = ref_round(t, r);
        end
        return t;
    endfunction

    function automatic void ref_init(input logic [63:0] k1, input logic [63:0] k2,
                                     input logic [63:0] n1, input logic [63:0] n2,
                                     input logic [63:0] iv);
        ref_key1  = k1;
        ref_key2  = k2;
        ref_state = ref_permute({n2, n1, k2, k1, iv}, 0);
        ref_state[192 +: 64] = ref_state[192 +: 64] ^ k1;
        ref_state[256 +: 64] = ref_state[256 +: 64] ^ k2;
    endfunction

    function automatic logic [127:0] ref_absorb(input logic [127:0] data,
                                                input int valid_bytes, input logic last);
        logic [7:0]   bytes [16];
        logic [63:0]  w0;
        logic [63:0]  w1;
        logic [127:0] ct;
        for (int k = 0; k < 16; k++) begin
            bytes[k] = data[127-8*k -: 8];
            if (last && k > valid_bytes) begin
                bytes[k] = 8'h00;
            end
        end
        if (last) begin
            bytes[valid_bytes] = 8'h01;
        end
        // Each half is loaded little-endian
        for (int k = 0; k < 8; k++) begin
            w0[8*k +: 8] = bytes[k];
            w1[8*k +: 8] = bytes[8+k];
        end
        ref_state[0 +: 64]  = ref_state[0 +: 64] ^ w0;
        ref_state[64 +: 64] = ref_state[64 +: 64] ^ w1;
        ct = {ref_state[64 +: 64], ref_state[0 +: 64]};
        ref_state = ref_permute(ref_state, 4);
        if (last) begin
            ref_state[319] = ~ref_state[319];
        end
        return ct;
    endfunction

    function automatic logic [127:0] ref_final();
        ref_state[128 +: 64] = ref_state[128 +: 64] ^ ref_key1;
        ref_state[192 +: 64] = ref_state[192 +: 64] ^ ref_key2;
        ref_state = ref_permute(ref_state, 0);
        return {ref_state[256 +: 64] ^ ref_key2, ref_state[192 +: 64] ^ ref_key1};
    endfunction

    // ------------------------------
    // Command driving
    task automatic wait_done();
        do begin
            @(negedge clk);
        end while (o_done !== 1'b1);
        @(negedge clk);
    endtask

    task automatic send_command(input int cmd, input bit stray);
        case (cmd)
            0: i_init = 1'b1;
            1: i_absorb = 1'b1;
            default: i_final = 1'b1;
        endcase
        @(negedge clk);
        i_init   = 1'b0;
        i_absorb = 1'b0;
        i_final  = 1'b0;
        if (stray) begin
            @(negedge clk);
            assert (o_busy === 1'b1) else begin
                stim_errors++;
                $display("Error at %0t: o_busy = %b, expected 1", $time, o_busy);
            end
            // Must be dropped, a reload here would spoil the tag
            i_init = 1'b1;
            @(negedge clk);
            i_init = 1'b0;
        end
        wait_done();
    endtask

    task automatic run_init();
        logic [127:0] r;
        draw_bits(64, r);
        i_key1 = r[63:0];
        draw_bits(64, r);
        i_key2 = r[63:0];
        draw_bits(64, r);
        i_nonce1 = r[63:0];
        draw_bits(64, r);
        i_nonce2 = r[63:0];
        draw_bits(64, r);
        i_iv = r[63:0];
        ref_init(i_key1, i_key2, i_nonce1, i_nonce2, i_iv);
        exp_kind_q.push_back(EXP_NONE);
        exp_value_q.push_back(128'd0);
        send_command(0, 1'b0);
    endtask

    task automatic run_absorb(input logic last, input int valid_bytes, input bit stray);
        logic [127:0] r;
        draw_bits(128, r);
        i_data        = r;
        i_valid_bytes = 4'(valid_bytes);
        i_last        = last;
        exp_kind_q.push_back(EXP_CT);
        exp_value_q.push_back(ref_absorb(r, valid_bytes, last));
        send_command(1, stray);
    endtask

    task automatic run_final();
        exp_kind_q.push_back(EXP_TAG);
        exp_value_q.push_back(ref_final());
        send_command(2, 1'b0);
    endtask

    // ------------------------------
    // Comparison, one falling edge after each o_done
    task automatic compare_result();
        int           kind;
        logic [127:0] value;
        if (result_idx >= exp_kind_q.size()) begin
            result_errors++;
            $display("Error at %0t: o_done pulsed with no command outstanding", $time);
        end else begin
            kind  = exp_kind_q[result_idx];
            value = exp_value_q[result_idx];
            result_idx++;
            result_checks++;
            assert (o_busy === 1'b0) else begin
                result_errors++;
                $display("Error at %0t: o_busy = %b, expected 0", $time, o_busy);
            end
            if (kind == EXP_CT) begin
                assert (o_ciphertext === value) else begin
                    result_errors++;
                    $display("Error at %0t: o_ciphertext = %h, expected %h",
                             $time, o_ciphertext, value);
                end
            end else if (kind == EXP_TAG) begin
                assert (o_tag === value) else begin
                    result_errors++;
                    $display("Error at %0t: o_tag = %h, expected %h", $time, o_tag, value);
                end
            end
        end
    endtask

    always @(negedge clk) begin
        if (done_seen) begin
            compare_result();
        end
        done_seen = reset_n_lfsr && (o_done === 1'b1);
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, a command never finished", cycle_count);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // ------------------------------
    // Stimulus
    initial begin
        logic [127:0] vb_bits;
        i_key1        = '0;
        i_key2        = '0;
        i_nonce1      = '0;
        i_nonce2      = '0;
        i_iv          = '0;
        i_data        = '0;
        i_valid_bytes = '0;
        i_last        = 1'b0;
        i_init        = 1'b0;
        i_absorb      = 1'b0;
        i_final       = 1'b0;
        lfsr_state    = 32'h1c52_8120;
        @(posedge reset_n_lfsr);

        // Idle after reset
        repeat (3) begin
            @(negedge clk);
            assert (o_busy === 1'b0 && o_done === 1'b0) else begin
                stim_errors++;
                $display("Error at %0t: o_busy = %b, o_done = %b, expected 0 and 0",
                         $time, o_busy, o_done);
            end
        end

        // Whole blocks, then an empty last block
        run_init();
        run_absorb(1'b0, 0, 1'b0);
        run_absorb(1'b0, 0, 1'b0);
        run_absorb(1'b1, 0, 1'b0);
        run_final();

        // Partial last blocks
        repeat (4) begin
            run_init();
            run_absorb(1'b0, 0, 1'b0);
            do begin
                draw_bits(4, vb_bits);
            end while (vb_bits[3:0] == 4'd0);
            run_absorb(1'b1, int'(vb_bits[3:0]), 1'b0);
            run_final();
        end

        // Stray command during an absorb run
        run_init();
        run_absorb(1'b1, 5, 1'b1);
        run_final();

        // No associated data
        run_init();
        run_final();

        repeat (2) @(negedge clk);
        assert (result_idx == exp_kind_q.size()) else begin
            stim_errors++;
            $display("Error: %0d commands never produced o_done",
                     exp_kind_q.size() - result_idx);
        end
        $display("Results checked: %0d, result errors: %0d, other errors: %0d",
                 result_checks, result_errors, stim_errors);
        if (result_errors == 0 && stim_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/ascon_properties.sv
// Concurrent checks on the sequencer outputs and their bind
`timescale 1ns/1ps
`default_nettype none

module ascon_properties (
    input wire logic clk,
    input wire logic reset_n_lfsr,
    input wire logic i_init,
    input wire logic i_absorb,
    input wire logic i_final,
    input wire logic o_load_init,
    input wire logic o_load_data,
    input wire logic o_load_final,
    input wire logic o_round_en,
    input wire logic o_busy,
    input wire logic o_done
);

    logic accept;
    logic strobe_any;

    assign accept     = !o_busy && (i_init || i_absorb || i_final);
    assign strobe_any = o_load_init || o_load_data || o_load_final || o_round_en;

    done_single_pulse: assert property (@(posedge clk) disable iff (!reset_n_lfsr)
        o_done |=> !o_done)
        else $error("o_done stayed high for more than one cycle");

    busy_after_accept: assert property (@(posedge clk) disable iff (!reset_n_lfsr)
        accept |=> o_busy)
        else $error("o_busy did not rise after an accepted command");

    busy_until_done: assert property (@(posedge clk) disable iff (!reset_n_lfsr)
        (o_busy && !o_done) |=> o_busy)
        else $error("o_busy fell before o_done");

    done_only_busy: assert property (@(posedge clk) disable iff (!reset_n_lfsr)
        o_done |-> o_busy)
        else $error("o_done pulsed while the sequencer was idle");

    no_strobe_idle: assert property (@(posedge clk) disable iff (!reset_n_lfsr)
        !o_busy |-> !strobe_any)
        else $error("load or round strobe active while idle");

endmodule

bind ascon_sequencer ascon_properties u_properties (
    .clk          (clk),
    .reset_n_lfsr (reset_n_lfsr),
    .i_init       (i_init),
    .i_absorb     (i_absorb),
    .i_final      (i_final),
    .o_load_init  (o_load_init),
    .o_load_data  (o_load_data),
    .o_load_final (o_load_final),
    .o_round_en   (o_round_en),
    .o_busy       (o_busy),
    .o_done       (o_done)
);

`default_nettype wire

// File: sim/tb_clock.sv
// Testbench clock and power-on reset
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic reset_n_lfsr
);

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Reset held for two rising edges, released on a falling edge
    initial begin
        reset_n_lfsr = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset_n_lfsr = 1'b1;
    end

endmodule

`default_nettype wire

// File: hw/ascon_core.sv
// Ascon core top: sequencer, state, round and absorb blocks
`timescale 1ns/1ps
`default_nettype none

module ascon_core (
    input  wire logic                                    clk,
    input  wire logic                                    reset_n_lfsr,
    input  wire logic [ascon_pkg::WORD_SIZE-1:0]         i_key1,
    input  wire logic [ascon_pkg::WORD_SIZE-1:0]         i_key2,
    input  wire logic [ascon_pkg::WORD_SIZE-1:0]         i_nonce1,
    input  wire logic [ascon_pkg::WORD_SIZE-1:0]         i_nonce2,
    input  wire logic [ascon_pkg::WORD_SIZE-1:0]         i_iv,
    input  wire logic [ascon_pkg::BLOCK_WIDTH-1:0]       i_data,
    input  wire logic [ascon_pkg::VALID_BYTES_WIDTH-1:0] i_valid_bytes,
    input  wire logic                                    i_last,
    input  wire logic                                    i_init,
    input  wire logic                                    i_absorb,
    input  wire logic                                    i_final,
    output logic      [ascon_pkg::BLOCK_WIDTH-1:0]       o_ciphertext,
    output logic      [ascon_pkg::BLOCK_WIDTH-1:0]       o_tag,
    output logic                                         o_busy,
    output logic                                         o_done
);

    ascon_pkg::phase_t                        phase;
    logic                                     last_block;
    logic                                     load_init;
    logic                                     load_data;
    logic                                     load_final;
    logic                                     round_en;
    logic [ascon_pkg::ROUND_IDX_WIDTH-1:0]    round_idx;
    logic                                     last_round;
    logic [ascon_pkg::STATE_WIDTH-1:0]        state;
    logic [ascon_pkg::STATE_WIDTH-1:0]        round_state;
    logic [ascon_pkg::WORD_SIZE-1:0]          abs_x0;
    logic [ascon_pkg::WORD_SIZE-1:0]          abs_x1;
    logic [ascon_pkg::BLOCK_WIDTH-1:0]        ciphertext;

    ascon_sequencer u_sequencer (
        .clk          (clk),
        .reset_n_lfsr (reset_n_lfsr),
        .i_init       (i_init),
        .i_absorb     (i_absorb),
        .i_final      (i_final),
        .i_last       (i_last),
        .o_phase      (phase),
        .o_last_block (last_block),
        .o_load_init  (load_init),
        .o_load_data  (load_data),
        .o_load_final (load_final),
        .o_round_en   (round_en),
        .o_round_idx  (round_idx),
        .o_last_round (last_round),
        .o_busy       (o_busy),
        .o_done       (o_done)
    );

    ascon_state u_state (
        .clk           (clk),
        .reset_n_lfsr  (reset_n_lfsr),
        .i_key1        (i_key1),
        .i_key2        (i_key2),
        .i_nonce1      (i_nonce1),
        .i_nonce2      (i_nonce2),
        .i_iv          (i_iv),
        .i_phase       (phase),
        .i_last_block  (last_block),
        .i_load_init   (load_init),
        .i_load_data   (load_data),
        .i_load_final  (load_final),
        .i_round_en    (round_en),
        .i_last_round  (last_round),
        .i_round_state (round_state),
        .i_abs_x0      (abs_x0),
        .i_abs_x1      (abs_x1),
        .i_ciphertext  (ciphertext),
        .o_state       (state),
        .o_ciphertext  (o_ciphertext),
        .o_tag         (o_tag)
    );

    ascon_round u_round (
        .i_state     (state),
        .i_round_idx (round_idx),
        .o_state     (round_state)
    );

    // Padding uses the last flag captured with the absorb command
    ascon_absorb u_absorb (
        .i_data        (i_data),
        .i_valid_bytes (i_valid_bytes),
        .i_last        (last_block),
        .i_x0          (state[0 +: ascon_pkg::WORD_SIZE]),
        .i_x1          (state[ascon_pkg::WORD_SIZE +: ascon_pkg::WORD_SIZE]),
        .o_x0          (abs_x0),
        .o_x1          (abs_x1),
        .o_ciphertext  (ciphertext)
    );

endmodule

`default_nettype wire

// File: hw/ascon_state.sv
// State register, key registers, load/round input select,
// last-round key and domain injection, ciphertext and tag registers
`timescale 1ns/1ps
`default_nettype none

module ascon_state (
    input  wire logic                              clk,
    input  wire logic                              reset_n_lfsr,
    input  wire logic [ascon_pkg::WORD_SIZE-1:0]   i_key1,
    input  wire logic [ascon_pkg::WORD_SIZE-1:0]   i_key2,
    input  wire logic [ascon_pkg::WORD_SIZE-1:0]   i_nonce1,
    input  wire logic [ascon_pkg::WORD_SIZE-1:0]   i_nonce2,
    input  wire logic [ascon_pkg::WORD_SIZE-1:0]   i_iv,
    input  ascon_pkg::phase_t                      i_phase,
    input  wire logic                              i_last_block,
    input  wire logic                              i_load_init,
    input  wire logic                              i_load_data,
    input  wire logic                              i_load_final,
    input  wire logic                              i_round_en,
    input  wire logic                              i_last_round,
    input  wire logic [ascon_pkg::STATE_WIDTH-1:0] i_round_state,
    input  wire logic [ascon_pkg::WORD_SIZE-1:0]   i_abs_x0,
    input  wire logic [ascon_pkg::WORD_SIZE-1:0]   i_abs_x1,
    input  wire logic [ascon_pkg::BLOCK_WIDTH-1:0] i_ciphertext,
    output logic      [ascon_pkg::STATE_WIDTH-1:0] o_state,
    output logic      [ascon_pkg::BLOCK_WIDTH-1:0] o_ciphertext,
    output logic      [ascon_pkg::BLOCK_WIDTH-1:0] o_tag
);

    localparam int W = ascon_pkg::WORD_SIZE;

    logic [W-1:0]                      key1_q;
    logic [W-1:0]                      key2_q;
    logic [ascon_pkg::STATE_WIDTH-1:0] round_next;
    logic                              tag_en;

    // ------------------------------
    // Round output with last-round injections
    always_comb begin
        round_next = i_round_state;
        if (i_last_round) begin
            case (i_phase)
                ascon_pkg::PH_INIT: begin
                    round_next[3*W +: W] = i_round_state[3*W +: W] ^ key1_q;
                    round_next[4*W +: W] = i_round_state[4*W +: W] ^ key2_q;
                end
                ascon_pkg::PH_DATA: begin
                    if (i_last_block) begin
                        round_next[4*W + ascon_pkg::DOMAIN_BIT] =
                            ~i_round_state[4*W + ascon_pkg::DOMAIN_BIT];
                    end
                end
                default: begin
                end
            endcase
        end
    end

    // ------------------------------
    // State register
    always_ff @(posedge clk or negedge reset_n_lfsr) begin
        if (!reset_n_lfsr) begin
            o_state <= '0;
        end else if (i_load_init) begin
            o_state <= {i_nonce2, i_nonce1, i_key2, i_key1, i_iv};
        end else if (i_load_data) begin
            o_state <= {o_state[2*W +: 3*W], i_abs_x1, i_abs_x0};
        end else if (i_load_final) begin
            // Key enters x2/x3 before finalization
            o_state <= {o_state[4*W +: W],
                        o_state[3*W +: W] ^ key2_q,
                        o_state[2*W +: W] ^ key1_q,
                        o_state[0 +: 2*W]};
        end else if (i_round_en) begin
            o_state <= round_next;
        end
    end

    assign tag_en = i_round_en & i_last_round & (i_phase == ascon_pkg::PH_FINAL);

    always_ff @(posedge clk) begin
        if (i_load_init) begin
            key1_q <= i_key1;
            key2_q <= i_key2;
        end
        if (i_load_data) begin
            o_ciphertext <= i_ciphertext;
        end
        if (tag_en) begin
            o_tag <= {i_round_state[4*W +: W] ^ key2_q, i_round_state[3*W +: W] ^ key1_q};
        end
    end

endmodule

`default_nettype wire

// File: hw/ascon_sequencer.sv
// Round sequencer: command accept, phase, round counter, busy and done
`timescale 1ns/1ps
`default_nettype none

module ascon_sequencer (
    input  wire logic                                clk,
    input  wire logic                                reset_n_lfsr,
    input  wire logic                                i_init,
    input  wire logic                                i_absorb,
    input  wire logic                                i_final,
    input  wire logic                                i_last,
    output ascon_pkg::phase_t                        o_phase,
    output logic                                     o_last_block,
    output logic                                     o_load_init,
    output logic                                     o_load_data,
    output logic                                     o_load_final,
    output logic                                     o_round_en,
    output logic [ascon_pkg::ROUND_IDX_WIDTH-1:0]    o_round_idx,
    output logic                                     o_last_round,
    output logic                                     o_busy,
    output logic                                     o_done
);

    logic load_any;

    assign load_any = o_load_init | o_load_data | o_load_final;

    always_ff @(posedge clk or negedge reset_n_lfsr) begin
        if (!reset_n_lfsr) begin
            o_phase      <= ascon_pkg::PH_IDLE;
            o_last_block <= 1'b0;
            o_load_init  <= 1'b0;
            o_load_data  <= 1'b0;
            o_load_final <= 1'b0;
            o_round_en   <= 1'b0;
            o_round_idx  <= '0;
            o_busy       <= 1'b0;
        end else begin
            o_load_init  <= 1'b0;
            o_load_data  <= 1'b0;
            o_load_final <= 1'b0;

            // Commands only count while idle
            if (!o_busy) begin
                if (i_init) begin
                    o_busy       <= 1'b1;
                    o_phase      <= ascon_pkg::PH_INIT;
                    o_last_block <= 1'b0;
                    o_load_init  <= 1'b1;
                end else if (i_absorb) begin
                    o_busy       <= 1'b1;
                    o_phase      <= ascon_pkg::PH_DATA;
                    o_last_block <= i_last;
                    o_load_data  <= 1'b1;
                end else if (i_final) begin
                    o_busy       <= 1'b1;
                    o_phase      <= ascon_pkg::PH_FINAL;
                    o_last_block <= 1'b0;
                    o_load_final <= 1'b1;
                end
            end

            // Rounds follow the load edge back to back
            if (load_any) begin
                o_round_en  <= 1'b1;
                o_round_idx <= (o_phase == ascon_pkg::PH_DATA) ?
                               ascon_pkg::IDX_START_B : ascon_pkg::IDX_START_A;
            end else if (o_round_en) begin
                if (o_last_round) begin
                    o_round_en <= 1'b0;
                    o_busy     <= 1'b0;
                    o_phase    <= ascon_pkg::PH_IDLE;
                end else begin
                    o_round_idx <= o_round_idx + 1'b1;
                end
            end
        end
    end

    assign o_last_round = (o_round_idx == ascon_pkg::IDX_LAST);
    assign o_done       = o_round_en & o_last_round;

endmodule

`default_nettype wire

// File: hw/ascon_absorb.sv
// Block absorption: 10* padding, byte reversal per half, XOR into x0/x1
`timescale 1ns/1ps
`default_nettype none

module ascon_absorb (
    input  wire logic [ascon_pkg::BLOCK_WIDTH-1:0]       i_data,
    input  wire logic [ascon_pkg::VALID_BYTES_WIDTH-1:0] i_valid_bytes,
    input  wire logic                                    i_last,
    input  wire logic [ascon_pkg::WORD_SIZE-1:0]         i_x0,
    input  wire logic [ascon_pkg::WORD_SIZE-1:0]         i_x1,
    output logic      [ascon_pkg::WORD_SIZE-1:0]         o_x0,
    output logic      [ascon_pkg::WORD_SIZE-1:0]         o_x1,
    output logic      [ascon_pkg::BLOCK_WIDTH-1:0]       o_ciphertext
);

    logic [ascon_pkg::BLOCK_WIDTH-1:0] padded;
    logic [ascon_pkg::BLOCK_WIDTH-1:0] reversed;

    // Byte 0 is the MSB byte of i_data
    for (genvar i = 0; i < ascon_pkg::BLOCK_WIDTH / 8; i++) begin : g_pad
        always_comb begin
            if (!i_last || (i_valid_bytes > ascon_pkg::VALID_BYTES_WIDTH'(i))) begin
                padded[ascon_pkg::BLOCK_WIDTH-1-8*i -: 8] =
                    i_data[ascon_pkg::BLOCK_WIDTH-1-8*i -: 8];
            end else if (i_valid_bytes == ascon_pkg::VALID_BYTES_WIDTH'(i)) begin
                padded[ascon_pkg::BLOCK_WIDTH-1-8*i -: 8] = 8'h01;
            end else begin
                padded[ascon_pkg::BLOCK_WIDTH-1-8*i -: 8] = 8'h00;
            end
        end
    end

    // Little-endian word load, bytes swap inside each 64-bit half
    for (genvar j = 0; j < ascon_pkg::WORD_SIZE / 8; j++) begin : g_rev
        assign reversed[ascon_pkg::WORD_SIZE + 8*j +: 8] =
            padded[ascon_pkg::WORD_SIZE + 8*(7-j) +: 8];
        assign reversed[8*j +: 8] = padded[8*(7-j) +: 8];
    end

    assign o_x0 = i_x0 ^ reversed[ascon_pkg::WORD_SIZE +: ascon_pkg::WORD_SIZE];
    assign o_x1 = i_x1 ^ reversed[0 +: ascon_pkg::WORD_SIZE];

    assign o_ciphertext = {o_x1, o_x0};

endmodule

`default_nettype wire

// File: hw/ascon_round.sv
// One full Ascon round: constant addition, substitution layer and
// linear diffusion over the five 64-bit words
`timescale 1ns/1ps
`default_nettype none

module ascon_round (
    input  wire logic [ascon_pkg::STATE_WIDTH-1:0]     i_state,
    input  wire logic [ascon_pkg::ROUND_IDX_WIDTH-1:0] i_round_idx,
    output logic      [ascon_pkg::STATE_WIDTH-1:0]     o_state
);

    logic [ascon_pkg::WORD_SIZE-1:0] x_rc  [ascon_pkg::COL_SIZE];
    logic [ascon_pkg::WORD_SIZE-1:0] x_af1 [ascon_pkg::COL_SIZE];
    logic [ascon_pkg::WORD_SIZE-1:0] x_chi [ascon_pkg::COL_SIZE];
    logic [ascon_pkg::WORD_SIZE-1:0] x_af2 [ascon_pkg::COL_SIZE];
    logic [ascon_pkg::WORD_SIZE-1:0] x_ld  [ascon_pkg::COL_SIZE];

    function automatic logic [ascon_pkg::WORD_SIZE-1:0] rotr(
        input logic [ascon_pkg::WORD_SIZE-1:0] x,
        input int                              n
    );
        return (x >> n) | (x << (ascon_pkg::WORD_SIZE - n));
    endfunction

    // ------------------------------
    // Constant addition into the low byte of x2
    always_comb begin
        for (int i = 0; i < ascon_pkg::COL_SIZE; i++) begin
            x_rc[i] = i_state[i*ascon_pkg::WORD_SIZE +: ascon_pkg::WORD_SIZE];
        end
        x_rc[2][7:0] = x_rc[2][7:0] ^ ascon_pkg::round_constant(i_round_idx);
    end

    // ------------------------------
    // Bitsliced S-box: affine, chi, affine
    always_comb begin
        x_af1[0] = x_rc[0] ^ x_rc[4];
        x_af1[1] = x_rc[1];
        x_af1[2] = x_rc[2] ^ x_rc[1];
        x_af1[3] = x_rc[3];
        x_af1[4] = x_rc[4] ^ x_rc[3];
    end

    for (genvar i = 0; i < ascon_pkg::COL_SIZE; i++) begin : g_chi
        assign x_chi[i] = x_af1[i]
                        ^ (~x_af1[(i + 1) % ascon_pkg::COL_SIZE]
                           & x_af1[(i + 2) % ascon_pkg::COL_SIZE]);
    end

    // x2 comes out inverted, the complement from chi is folded in here
    always_comb begin
        x_af2[0] = x_chi[0] ^ x_chi[4];
        x_af2[1] = x_chi[1] ^ x_chi[0];
        x_af2[2] = ~x_chi[2];
        x_af2[3] = x_chi[3] ^ x_chi[2];
        x_af2[4] = x_chi[4];
    end

    // ------------------------------
    // Linear diffusion
    for (genvar i = 0; i < ascon_pkg::COL_SIZE; i++) begin : g_diff
        assign x_ld[i] = x_af2[i]
                       ^ rotr(x_af2[i], ascon_pkg::ROT_A[i])
                       ^ rotr(x_af2[i], ascon_pkg::ROT_B[i]);
        assign o_state[i*ascon_pkg::WORD_SIZE +: ascon_pkg::WORD_SIZE] = x_ld[i];
    end

endmodule

`default_nettype wire

// File: hw/ascon_pkg.sv
// Shared widths, round counts, linear-layer rotations and round constants
// for the one-round-per-cycle Ascon datapath
`default_nettype none

package ascon_pkg;

    // ------------------------------
    // Widths
    localparam int WORD_SIZE         = 64;
    localparam int COL_SIZE          = 5;
    localparam int STATE_WIDTH       = WORD_SIZE * COL_SIZE;
    localparam int BLOCK_WIDTH       = 128;
    localparam int VALID_BYTES_WIDTH = 4;

    // ------------------------------
    // Round counts
    localparam int ROUNDS_A        = 12;
    localparam int ROUNDS_B        = 8;
    localparam int ROUND_IDX_WIDTH = 4;

    // 12-round runs start at 0, 8-round runs at 4, both end at 11
    localparam logic [ROUND_IDX_WIDTH-1:0] IDX_START_A = '0;
    localparam logic [ROUND_IDX_WIDTH-1:0] IDX_START_B = ROUND_IDX_WIDTH'(ROUNDS_A - ROUNDS_B);
    localparam logic [ROUND_IDX_WIDTH-1:0] IDX_LAST    = ROUND_IDX_WIDTH'(ROUNDS_A - 1);

    // Linear diffusion, one pair of right rotations per word
    localparam int ROT_A [COL_SIZE] = '{19, 61, 1, 10, 7};
    localparam int ROT_B [COL_SIZE] = '{28, 39, 6, 17, 41};

    // Domain separation flips this bit of x4 after the last data block
    localparam int DOMAIN_BIT = 63;

    // ------------------------------
    // Run phase, held by the sequencer for a whole run
    typedef enum logic [1:0] {
        PH_IDLE  = 2'd0,
        PH_INIT  = 2'd1,
        PH_DATA  = 2'd2,
        PH_FINAL = 2'd3
    } phase_t;

    // Byte XORed into the low end of x2 in round r
    function automatic logic [7:0] round_constant(input logic [ROUND_IDX_WIDTH-1:0] r);
        logic [7:0] r_ext;
        r_ext = {{(8 - ROUND_IDX_WIDTH){1'b0}}, r};
        return 8'hF0 - (8'h0F * r_ext);
    endfunction

endpackage

`default_nettype wire
